// File: source/mult_config.svh
`ifndef MULT_CONFIG_SVH
`define MULT_CONFIG_SVH

// Operand width of S and B, and of the A accumulator
`define MUL_WIDTH 8

// Flops in each button synchronizer
`define SYNC_STAGES 2

// Wide enough for 17 sequencer states
`define STATE_BITS 5

`endif

// File: source/mulCtrlPkg.sv
`include "mult_config.svh"

package mulCtrlPkg;

    // Even states add or subtract, odd states shift
    typedef enum logic [`STATE_BITS-1:0] {
        S0,
        S1,
        S2,
        S3,
        S4,
        S5,
        S6,
        S7,
        S8,
        S9,
        S10,
        S11,
        S12,
        S13,
        S14,
        S15,
        S16     // Wait for Run or ClearA_LoadB
    } seqState_t;

    // Datapath command, at most one bit per cycle
    typedef struct packed {
        logic clearLoad;    // X,A <- 0 and B <- S
        logic clearA;       // X,A <- 0 at run start
        logic shift;        // Arithmetic shift of X:A:B
        logic add;          // X:A <- A + S
        logic sub;          // X:A <- A - S
    } dpCmd_t;

endpackage

// File: source/mulDataPkg.sv
`include "mult_config.svh"

package mulDataPkg;

    // Sign bit, accumulator and multiplier register
    typedef struct packed {
        logic                  x;
        logic [`MUL_WIDTH-1:0] a;
        logic [`MUL_WIDTH-1:0] b;
    } regFile_t;

    // A:B seen either as the signed product or as two bytes
    typedef union packed {
        logic signed [2*`MUL_WIDTH-1:0] prod;
        struct packed {
            logic [`MUL_WIDTH-1:0] hi;  // Register A
            logic [`MUL_WIDTH-1:0] lo;  // Register B
        } parts;
    } product_u;

endpackage

// File: source/inputConditioner.sv
`timescale 1ns/10ps
`include "mult_config.svh"

module inputConditioner
(
    input  logic Clk,
    input  logic rst,
    input  logic Run,
    input  logic ClearA_LoadB,
    output logic runPulse,
    output logic loadPulse
);

    // Bit 0 is Run, bit 1 is ClearA_LoadB
    logic [1:0] btnIn;
    logic [`SYNC_STAGES-1:0][1:0] syncChain;
    logic [1:0] btnLevel;
    logic [1:0] btnPrev;
    logic [1:0] btnPulse;

    assign btnIn    = {ClearA_LoadB, Run};
    assign btnLevel = syncChain[`SYNC_STAGES-1];  // Last synchronizer stage

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            syncChain <= '0;
            btnPrev   <= '0;
            btnPulse  <= '0;
        end
        else
        begin
            syncChain <= {syncChain[`SYNC_STAGES-2:0], btnIn};
            btnPrev   <= btnLevel;
            btnPulse  <= btnLevel & ~btnPrev;     // Registered rising edge
        end
    end

    assign runPulse  = btnPulse[0];
    assign loadPulse = btnPulse[1];

    // Coincident pulses only when both pins rose on the same sampled edge
    bothPulsesNeedJointRise: assert property (@(posedge Clk) disable iff (rst)
        (runPulse && loadPulse) |->
            ($past(Run, `SYNC_STAGES+1) && !$past(Run, `SYNC_STAGES+2) &&
             $past(ClearA_LoadB, `SYNC_STAGES+1) && !$past(ClearA_LoadB, `SYNC_STAGES+2)));

endmodule

// File: source/multControl.sv
`timescale 1ns/10ps
`include "mult_config.svh"

module multControl
(
    input  logic                Clk,
    input  logic                rst,
    input  logic                runPulse,
    input  logic                loadPulse,
    input  logic                M,          // Low bit of B
    output mulCtrlPkg::dpCmd_t  cmd,
    output logic                Busy
);

    // Final add/sub step is a subtract, as B's top bit carries negative weight
    localparam mulCtrlPkg::seqState_t LastAddState =
        mulCtrlPkg::seqState_t'(2*(`MUL_WIDTH-1));
    localparam mulCtrlPkg::seqState_t LastShiftState =
        mulCtrlPkg::seqState_t'(2*`MUL_WIDTH-1);

    mulCtrlPkg::seqState_t state;
    mulCtrlPkg::seqState_t nextState;

    always_ff @(posedge Clk)
    begin
        if (rst)
            state <= mulCtrlPkg::S16;
        else
            state <= nextState;
    end

    always_comb
    begin
        nextState = state;
        if (state == mulCtrlPkg::S16)
        begin
            if (runPulse)
                nextState = mulCtrlPkg::S0;
        end
        else if (state == LastShiftState)
            nextState = mulCtrlPkg::S16;
        else
            nextState = mulCtrlPkg::seqState_t'(state + 1'b1);   // Walk through the steps
    end

    // Moore part from state, Mealy part from M and the pulses
    always_comb
    begin
        cmd = '0;
        if (state == mulCtrlPkg::S16)
        begin
            if (runPulse)
                cmd.clearA = 1'b1;      // Run wins over a simultaneous load
            else if (loadPulse)
                cmd.clearLoad = 1'b1;
        end
        else if (state[0])
            cmd.shift = 1'b1;
        else if (M)
        begin
            if (state == LastAddState)
                cmd.sub = 1'b1;
            else
                cmd.add = 1'b1;
        end
    end

    assign Busy = (state != mulCtrlPkg::S16);

    cmdOneHot: assert property (@(posedge Clk) disable iff (rst)
        $onehot0(cmd));

    // Every add/sub slot is followed by a shift, whether or not M was set
    shiftAfterAddSub: assert property (@(posedge Clk) disable iff (rst)
        (Busy && !state[0]) |=> cmd.shift);

    waitOnlyLeftOnRun: assert property (@(posedge Clk) disable iff (rst)
        (state == mulCtrlPkg::S16 && !runPulse) |=> state == mulCtrlPkg::S16);

endmodule

// File: source/multDatapath.sv
`timescale 1ns/10ps
`include "mult_config.svh"

module multDatapath
(
    input  logic                    Clk,
    input  logic                    rst,
    input  logic [`MUL_WIDTH-1:0]   S,
    input  mulCtrlPkg::dpCmd_t      cmd,
    output mulDataPkg::regFile_t    regs
);

    logic [`MUL_WIDTH:0] aExt;
    logic [`MUL_WIDTH:0] sExt;
    logic [`MUL_WIDTH:0] addSub;

    // Sign-extend both operands to 9 bits so X picks up the true sign
    assign aExt = {regs.a[`MUL_WIDTH-1], regs.a};
    assign sExt = {S[`MUL_WIDTH-1], S};

    always_comb
    begin
        if (cmd.sub)
            addSub = aExt - sExt;
        else
            addSub = aExt + sExt;
    end

    always_ff @(posedge Clk)
    begin
        if (rst)
            regs <= '0;
        else if (cmd.clearLoad)
        begin
            regs.x <= 1'b0;
            regs.a <= '0;
            regs.b <= S;            // New multiplier from the switches
        end
        else if (cmd.clearA)
        begin
            regs.x <= 1'b0;
            regs.a <= '0;
        end
        else if (cmd.add || cmd.sub)
            {regs.x, regs.a} <= addSub;
        else if (cmd.shift)
        begin
            // X feeds A's top bit and stays put
            {regs.a, regs.b} <= {regs.x, regs.a, regs.b[`MUL_WIDTH-1:1]};
        end
    end

    // Sign is replicated by the shift, never altered
    shiftKeepsX: assert property (@(posedge Clk) disable iff (rst)
        cmd.shift |=> regs.x == $past(regs.x));

endmodule

// File: source/hexDisplay.sv
`timescale 1ns/10ps
`include "mult_config.svh"

module hexDisplay
(
    input  mulDataPkg::product_u    word,
    output logic [6:0]              HexAU,
    output logic [6:0]              HexAL,
    output logic [6:0]              HexBU,
    output logic [6:0]              HexBL
);

    // Segment order gfedcba, a low bit lights the segment
    function automatic logic [6:0] hexToSeg(input logic [3:0] nib);
        case (nib)
            4'h0: hexToSeg = 7'b1000000;
            4'h1: hexToSeg = 7'b1111001;
            4'h2: hexToSeg = 7'b0100100;
            4'h3: hexToSeg = 7'b0110000;
            4'h4: hexToSeg = 7'b0011001;
            4'h5: hexToSeg = 7'b0010010;
            4'h6: hexToSeg = 7'b0000010;
            4'h7: hexToSeg = 7'b1111000;
            4'h8: hexToSeg = 7'b0000000;
            4'h9: hexToSeg = 7'b0010000;
            4'hA: hexToSeg = 7'b0001000;
            4'hB: hexToSeg = 7'b0000011;    // Lower-case b
            4'hC: hexToSeg = 7'b1000110;
            4'hD: hexToSeg = 7'b0100001;    // Lower-case d
            4'hE: hexToSeg = 7'b0000110;
            default: hexToSeg = 7'b0001110;
        endcase
    endfunction

    assign HexAU = hexToSeg(word.parts.hi[`MUL_WIDTH-1 -: 4]);
    assign HexAL = hexToSeg(word.parts.hi[3:0]);
    assign HexBU = hexToSeg(word.parts.lo[`MUL_WIDTH-1 -: 4]);
    assign HexBL = hexToSeg(word.parts.lo[3:0]);

endmodule

// File: source/multiplierTop.sv
`timescale 1ns/10ps
`include "mult_config.svh"

module multiplierTop
(
    input  logic                            Clk,
    input  logic                            rst,
    input  logic                            Run,
    input  logic                            ClearA_LoadB,
    input  logic [`MUL_WIDTH-1:0]           S,
    output logic                            Xval,
    output logic [`MUL_WIDTH-1:0]           Aval,
    output logic [`MUL_WIDTH-1:0]           Bval,
    output logic signed [2*`MUL_WIDTH-1:0]  Product,
    output logic                            Busy,
    output logic [6:0]                      HexAU,
    output logic [6:0]                      HexAL,
    output logic [6:0]                      HexBU,
    output logic [6:0]                      HexBL
);

    logic                   runPulse;
    logic                   loadPulse;
    mulCtrlPkg::dpCmd_t     cmd;
    mulDataPkg::regFile_t   regs;
    mulDataPkg::product_u   prodWord;

    inputConditioner u_inputConditioner (
        .Clk          (Clk),
        .rst          (rst),
        .Run          (Run),
        .ClearA_LoadB (ClearA_LoadB),
        .runPulse     (runPulse),
        .loadPulse    (loadPulse)
    );

    multControl u_multControl (
        .Clk       (Clk),
        .rst       (rst),
        .runPulse  (runPulse),
        .loadPulse (loadPulse),
        .M         (regs.b[0]),     // Multiplier bit under test
        .cmd       (cmd),
        .Busy      (Busy)
    );

    multDatapath u_multDatapath (
        .Clk  (Clk),
        .rst  (rst),
        .S    (S),
        .cmd  (cmd),
        .regs (regs)
    );

    // A is the high byte of the product, B the low byte
    assign prodWord.parts = {regs.a, regs.b};

    hexDisplay u_hexDisplay (
        .word  (prodWord),
        .HexAU (HexAU),
        .HexAL (HexAL),
        .HexBU (HexBU),
        .HexBL (HexBL)
    );

    assign Xval    = regs.x;
    assign Aval    = regs.a;
    assign Bval    = regs.b;
    assign Product = prodWord.prod;

endmodule

// File: testbench/tb_multiplier.sv
`timescale 1ns/10ps

module tb_multiplier;

    localparam int NumDirected    = 6;
    localparam int NumRandom      = 200;
    localparam int NumConsecutive = 3;
    localparam int NumIgnored     = 2;
    localparam int NumTests       = 1 + NumDirected + NumRandom + NumConsecutive + NumIgnored;
    localparam int TimeoutCycles  = NumTests * 40 + 200;

    // Common-cathode hex digits in gfedcba order where a high bit lights the segment
    localparam logic [6:0] litSegments [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    // Corner pairs as S value and B value
    localparam logic [7:0] directedS [NumDirected] = '{8'h00, 8'h01, 8'h80, 8'h7F, 8'hFF, 8'h07};
    localparam logic [7:0] directedB [NumDirected] = '{8'h00, 8'hFF, 8'h80, 8'h80, 8'hFF, 8'h3B};

    logic               Clk = 1'b0;
    logic               rst;
    logic               Run;
    logic               ClearA_LoadB;
    logic [7:0]         S;
    logic               Xval;
    logic [7:0]         Aval;
    logic [7:0]         Bval;
    logic signed [15:0] Product;
    logic               Busy;
    logic [6:0]         HexAU;
    logic [6:0]         HexAL;
    logic [6:0]         HexBU;
    logic [6:0]         HexBL;

    logic [15:0]        expQ[$];        // Expected products of pending runs
    string              nameQ[$];
    logic [15:0]        lastProduct;
    int                 issuedRuns = 0;
    int                 checkedRuns = 0;
    int                 passCount = 0;
    int                 failCount = 0;
    int                 cycleCount = 0;

    multiplierTop u_dut (
        .Clk          (Clk),
        .rst          (rst),
        .Run          (Run),
        .ClearA_LoadB (ClearA_LoadB),
        .S            (S),
        .Xval         (Xval),
        .Aval         (Aval),
        .Bval         (Bval),
        .Product      (Product),
        .Busy         (Busy),
        .HexAU        (HexAU),
        .HexAL        (HexAL),
        .HexBU        (HexBU),
        .HexBL        (HexBL)
    );

    always #20 Clk = ~Clk;

    always @(posedge Clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles)
        begin
            $display("ERROR run stopped after %0d cycles without finishing", cycleCount);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Signed byte times signed byte
    function automatic logic [15:0] refMultiply(input logic [7:0] s, input logic [7:0] b);
        logic signed [15:0] sWide;
        logic signed [15:0] bWide;
        sWide = {{8{s[7]}}, s};
        bWide = {{8{b[7]}}, b};
        refMultiply = sWide * bWide;
    endfunction

    // Display pins are active low
    function automatic logic [6:0] segPattern(input logic [3:0] nib);
        segPattern = ~litSegments[nib];
    endfunction

    task automatic reportMismatch(input string testName, input string field,
                                  input logic [15:0] expVal, input logic [15:0] actVal);
        $display("FAILED %s: %s expected %h, actual %h", testName, field, expVal, actVal);
    endtask

    task automatic recordResult(input string testName, input bit ok);
        if (ok)
        begin
            passCount++;
            $display("ok      %s", testName);
        end
        else
            failCount++;
    endtask

    // Hold for 4 cycles, then release for 4
    task automatic pressButtons(input logic runLvl, input logic loadLvl);
        @(posedge Clk);
        Run          <= runLvl;
        ClearA_LoadB <= loadLvl;
        repeat (4) @(posedge Clk);
        Run          <= 1'b0;
        ClearA_LoadB <= 1'b0;
        repeat (4) @(posedge Clk);
    endtask

    task automatic loadOperand(input logic [7:0] b, input string testName);
        bit ok;
        ok = 1'b1;
        @(posedge Clk);
        S            <= b;
        ClearA_LoadB <= 1'b1;
        repeat (4) @(posedge Clk);     // B is written on this edge
        ClearA_LoadB <= 1'b0;
        @(negedge Clk);
        if (Bval !== b)
        begin
            reportMismatch(testName, "Bval", {8'h00, b}, {8'h00, Bval});
            ok = 1'b0;
        end
        if (Aval !== 8'h00)
        begin
            reportMismatch(testName, "Aval", 16'h0000, {8'h00, Aval});
            ok = 1'b0;
        end
        if (Xval !== 1'b0)
        begin
            reportMismatch(testName, "Xval", 16'h0000, {15'd0, Xval});
            ok = 1'b0;
        end
        recordResult(testName, ok);
        repeat (4) @(posedge Clk);
    endtask

    task automatic startRun(input logic [7:0] s, input logic [15:0] expected, input string testName);
        @(posedge Clk);
        S <= s;
        expQ.push_back(expected);
        nameQ.push_back(testName);
        issuedRuns++;
        lastProduct = expected;
        pressButtons(1'b1, 1'b0);
    endtask

    task automatic waitForCheck();
        wait (checkedRuns == issuedRuns);
    endtask

    task automatic multiplyTest(input logic [7:0] s, input logic [7:0] b, input string testName);
        loadOperand(b, {testName, " load"});
        startRun(s, refMultiply(s, b), testName);
        waitForCheck();
    endtask

    // Compares each run once Busy has dropped
    initial
    begin
        logic [15:0] expected;
        string       testName;
        int          busyCycles;
        bit          ok;
        forever
        begin
            @(posedge Busy);
            busyCycles = 0;
            while (Busy === 1'b1)
            begin
                @(negedge Clk);
                if (Busy === 1'b1)
                    busyCycles++;
            end
            if (expQ.size() == 0)
            begin
                $display("ERROR Busy went high although no run was started");
                failCount++;
            end
            else
            begin
                expected = expQ.pop_front();
                testName = nameQ.pop_front();
                ok = 1'b1;
                if (Product !== expected)
                begin
                    reportMismatch(testName, "Product", expected, Product);
                    ok = 1'b0;
                end
                if (Xval !== expected[15])
                begin
                    reportMismatch(testName, "Xval", {15'd0, expected[15]}, {15'd0, Xval});
                    ok = 1'b0;
                end
                if ({Aval, Bval} !== expected)
                begin
                    reportMismatch(testName, "Aval:Bval", expected, {Aval, Bval});
                    ok = 1'b0;
                end
                if (busyCycles != 16)
                begin
                    reportMismatch(testName, "Busy cycles", 16'd16, 16'(busyCycles));
                    ok = 1'b0;
                end
                if ({HexAU, HexAL, HexBU, HexBL} !== {segPattern(expected[15:12]),
                    segPattern(expected[11:8]), segPattern(expected[7:4]),
                    segPattern(expected[3:0])})
                begin
                    reportMismatch(testName, "HexAU", {9'd0, segPattern(expected[15:12])},
                                   {9'd0, HexAU});
                    reportMismatch(testName, "HexAL", {9'd0, segPattern(expected[11:8])},
                                   {9'd0, HexAL});
                    reportMismatch(testName, "HexBU", {9'd0, segPattern(expected[7:4])},
                                   {9'd0, HexBU});
                    reportMismatch(testName, "HexBL", {9'd0, segPattern(expected[3:0])},
                                   {9'd0, HexBL});
                    ok = 1'b0;
                end
                recordResult(testName, ok);
            end
            checkedRuns++;
        end
    end

    initial
    begin
        logic [31:0] randWord;
        logic [7:0]  sVal;
        logic [7:0]  bVal;
        bit          ok;
        rst          = 1'b1;
        Run          = 1'b0;
        ClearA_LoadB = 1'b0;
        S            = 8'h00;
        void'($urandom(32'h110a_96cb));
        repeat (8) @(posedge Clk);
        rst <= 1'b0;
        @(negedge Clk);

        ok = 1'b1;
        if (Busy !== 1'b0)
        begin
            reportMismatch("after reset", "Busy", 16'h0000, {15'd0, Busy});
            ok = 1'b0;
        end
        if (Xval !== 1'b0)
        begin
            reportMismatch("after reset", "Xval", 16'h0000, {15'd0, Xval});
            ok = 1'b0;
        end
        if ({Aval, Bval} !== 16'h0000)
        begin
            reportMismatch("after reset", "Aval:Bval", 16'h0000, {Aval, Bval});
            ok = 1'b0;
        end
        recordResult("after reset", ok);

        for (int i = 0; i < NumDirected; i++)
            multiplyTest(directedS[i], directedB[i], $sformatf("directed %0d * %0d",
                         $signed(directedS[i]), $signed(directedB[i])));

        for (int i = 0; i < NumRandom; i++)
        begin
            randWord = $urandom();
            sVal = randWord[7:0];
            bVal = randWord[15:8];
            multiplyTest(sVal, bVal, $sformatf("random %0d * %0d", $signed(sVal), $signed(bVal)));
        end

        // B keeps the low byte of the previous product
        for (int i = 0; i < NumConsecutive; i++)
        begin
            randWord = $urandom();
            sVal = randWord[7:0];
            startRun(sVal, refMultiply(sVal, lastProduct[7:0]),
                     $sformatf("consecutive run %0d", i));
            waitForCheck();
        end

        // Presses land while the sequencer is busy
        loadOperand(8'hA5, "busy run press load");
        startRun(8'h3C, refMultiply(8'h3C, 8'hA5), "run press during Busy");
        pressButtons(1'b1, 1'b0);
        waitForCheck();
        loadOperand(8'h96, "busy load press load");
        startRun(8'hD3, refMultiply(8'hD3, 8'h96), "load press during Busy");
        pressButtons(1'b0, 1'b1);
        waitForCheck();

        repeat (4) @(posedge Clk);
        $display("Tests run %0d, passed %0d, failed %0d", passCount + failCount,
                 passCount, failCount);
        if (failCount == 0 && expQ.size() == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: src.f
+incdir+source
source/mulCtrlPkg.sv
source/mulDataPkg.sv
source/inputConditioner.sv
source/multControl.sv
source/multDatapath.sv
source/hexDisplay.sv
source/multiplierTop.sv
testbench/tb_multiplier.sv

// File: Makefile
# Verilator build and run of the add-shift multiplier testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
	    --top-module tb_multiplier -Mdir obj_dir -f src.f
	./obj_dir/Vtb_multiplier | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
